// File: filelist.f
design/rv_mem_pkg.sv
design/data_ram.sv
design/mem_access_unit.sv
design/mem_stage.sv
design/mem_top.sv
tests/tb_mem_top.sv

// File: Makefile
# Verilator build and run of the memory stage testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_mem_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timescale 1ns/1ps -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result; a crash of the binary also stops make
run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "^TEST PASSED$$" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_mem_top.sv
// Random-stimulus testbench for the memory stage and its data RAM
// Byte-array memory model and a queue of expected results

module tb_mem_top;
  timeunit 1ns;
  timeprecision 1ps;

  import rv_mem_pkg::*;

  localparam int RAM_WORDS  = 512;
  localparam int RAM_BYTES  = RAM_WORDS * 8;
  localparam int WAIT_LIMIT = 100;
  localparam int KIND_STORE = 0;
  localparam int KIND_LOAD  = 1;

  typedef struct packed {
    logic [63:0] pc;
    logic [31:0] inst;
    logic [4:0]  rd;
    logic        rd_wen;
    logic [63:0] rd_wdata;
    logic [63:0] rdata;
  } result_t;

  logic     clk;
  logic     rst;
  logic     i_executed_req;
  logic     o_executed_ack;
  xlen_t    i_pc;
  inst_t    i_inst;
  xlen_t    i_addr;
  logic     i_ren;
  logic     i_wen;
  funct3_t  i_funct3;
  xlen_t    i_wdata;
  reg_idx_t i_rd;
  logic     i_rd_wen;
  xlen_t    i_rd_wdata;
  logic     o_memoryed_req;
  logic     i_memoryed_ack;
  xlen_t    o_pc;
  inst_t    o_inst;
  reg_idx_t o_rd;
  logic     o_rd_wen;
  xlen_t    o_rd_wdata;
  xlen_t    o_rdata;

  logic [7:0]  model_mem [RAM_BYTES];
  result_t     exp_q [$];
  logic [31:0] stim_rng;
  logic [31:0] ack_rng;
  logic [63:0] pc_next;
  int          ack_mode;  // 0 keeps write-back ready, 1 stalls it in random stretches
  int          n_checks;
  int          n_errors;
  int          n_accepts;
  int          n_results;
  int          stalls;
  logic        prev_accept;
  logic        hold_valid;
  logic        timed_out;
  result_t     held;

  mem_top #(
    .RAM_WORDS (RAM_WORDS)
  ) i_dut (
    .clk            (clk),
    .rst            (rst),
    .i_executed_req (i_executed_req),
    .o_executed_ack (o_executed_ack),
    .i_pc           (i_pc),
    .i_inst         (i_inst),
    .i_addr         (i_addr),
    .i_ren          (i_ren),
    .i_wen          (i_wen),
    .i_funct3       (i_funct3),
    .i_wdata        (i_wdata),
    .i_rd           (i_rd),
    .i_rd_wen       (i_rd_wen),
    .i_rd_wdata     (i_rd_wdata),
    .o_memoryed_req (o_memoryed_req),
    .i_memoryed_ack (i_memoryed_ack),
    .o_pc           (o_pc),
    .o_inst         (o_inst),
    .o_rd           (o_rd),
    .o_rd_wen       (o_rd_wen),
    .o_rd_wdata     (o_rd_wdata),
    .o_rdata        (o_rdata)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_stim();
    stim_rng = xorshift(stim_rng);
    return stim_rng;
  endfunction

  // Address inside the RAM, aligned to the access size
  function automatic logic [63:0] rand_addr(input logic [2:0] f3);
    logic [31:0] r;
    int          size;
    r    = rand_stim();
    size = 1 << f3[1:0];
    return {32'd0, (r % RAM_BYTES) / size * size};
  endfunction

  function automatic logic [63:0] model_load(input logic [63:0] addr, input logic [2:0] f3);
    int          nbytes;
    int          base;
    logic [63:0] v;
    nbytes = 1 << f3[1:0];
    base   = int'(addr);
    v      = '0;
    for (int i = 0; i < nbytes; i++) begin
      v[i*8 +: 8] = model_mem[base + i];
    end
    if (!f3[2] && nbytes < 8 && v[nbytes*8-1]) begin
      v = v | (~64'd0 << (nbytes * 8));  // Signed loads copy the top bit upward
    end
    return v;
  endfunction

  function automatic void model_store(input logic [63:0] addr, input logic [2:0] f3,
                                      input logic [63:0] data);
    int nbytes;
    int base;
    nbytes = 1 << f3[1:0];
    base   = int'(addr);
    for (int i = 0; i < nbytes; i++) begin
      model_mem[base + i] = data[i*8 +: 8];
    end
  endfunction

  function automatic result_t current_outputs();
    return {o_pc, o_inst, o_rd, o_rd_wen, o_rd_wdata, o_rdata};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    n_checks++;
    if (got !== expected) begin
      n_errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic compare_result(input result_t got, input result_t expd);
    check_value("o_pc", got.pc, expd.pc);
    check_value("o_inst", 64'(got.inst), 64'(expd.inst));
    check_value("o_rd", 64'(got.rd), 64'(expd.rd));
    check_value("o_rd_wen", 64'(got.rd_wen), 64'(expd.rd_wen));
    check_value("o_rd_wdata", got.rd_wdata, expd.rd_wdata);
    check_value("o_rdata", got.rdata, expd.rdata);
  endtask

  task automatic report_and_finish();
    $display("checks: %0d, errors: %0d, accepted: %0d, results: %0d",
             n_checks, n_errors, n_accepts, n_results);
    if (n_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout at %0t ns: %s took more than %0d cycles", $time, what, WAIT_LIMIT);
    n_errors++;
    timed_out = 1'b1;
  endtask

  // Applies stores to the model and queues what the write-back side must see
  task automatic record_accept();
    result_t expd;
    expd = {i_pc, i_inst, i_rd, i_rd_wen, i_rd_wdata, 64'd0};
    if (i_wen) begin
      model_store(i_addr, i_funct3, i_wdata);
    end else if (i_ren) begin
      expd.rdata = model_load(i_addr, i_funct3);
    end
    exp_q.push_back(expd);
    n_accepts++;
  endtask

  // Runs at the falling edge, where inputs and outputs are settled
  task automatic watch_outputs();
    result_t got;
    got = current_outputs();
    if (prev_accept) begin
      check_value("o_memoryed_req after accept", 64'(o_memoryed_req), 64'd1);
    end
    if (hold_valid) begin
      check_value("o_memoryed_req while held", 64'(o_memoryed_req), 64'd1);
      compare_result(got, held);
    end
    if (!o_memoryed_req) begin
      compare_result(got, '0);
    end
    hold_valid = o_memoryed_req && !i_memoryed_ack;
    if (hold_valid) begin
      check_value("o_executed_ack", 64'(o_executed_ack), 64'd0);
      held = got;
    end
    if (o_memoryed_req && i_memoryed_ack) begin
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("A result was offered at %0t ns with no instruction outstanding", $time);
      end else begin
        compare_result(got, exp_q.pop_front());
      end
      n_results++;
    end
    prev_accept = i_executed_req && o_executed_ack;
    if (prev_accept) begin
      record_accept();
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      watch_outputs();
    end
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    int stretch;
    stretch = 0;
    forever begin
      @(posedge clk);
      #1;
      if (ack_mode == 0) begin
        i_memoryed_ack = 1'b1;
      end else begin
        if (stretch == 0) begin
          ack_rng        = xorshift(ack_rng);
          i_memoryed_ack = ack_rng[0];
          stretch        = int'(ack_rng[3:1]) + 1;
        end
        stretch--;
      end
    end
  end

  // Called one step after a rising edge; returns one step after the accepting edge
  task automatic send_instr(input int kind, input logic [2:0] f3, input logic [63:0] addr,
                            input logic [63:0] wdata);
    logic [31:0] r;
    int          waited;
    r              = rand_stim();
    i_executed_req = 1'b1;
    i_pc           = pc_next;
    i_inst         = rand_stim();
    i_addr         = addr;
    i_ren          = (kind == KIND_LOAD);
    i_wen          = (kind == KIND_STORE);
    i_funct3       = f3;
    i_wdata        = wdata;
    i_rd           = r[4:0];
    i_rd_wen       = r[5];
    i_rd_wdata     = {rand_stim(), rand_stim()};
    pc_next        = pc_next + 64'd4;
    waited         = 0;
    @(negedge clk);
    while (!o_executed_ack && !timed_out) begin
      if (waited == WAIT_LIMIT) begin
        timeout_fail("acceptance of an instruction");
      end else begin
        waited++;
        stalls++;
        @(negedge clk);
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send_random(input int kind);
    logic [31:0] r;
    logic [2:0]  f3;
    r = rand_stim();
    if (kind == KIND_STORE) begin
      f3 = 3'(r % 4);
    end else if (kind == KIND_LOAD) begin
      f3 = 3'(r % 7);  // Code 111 is no load
    end else begin
      f3 = r[2:0];  // Non-memory kind passes any code through unchanged
    end
    send_instr(kind, f3, rand_addr(f3), {rand_stim(), rand_stim()});
  endtask

  task automatic idle_cycles(input int n);
    i_executed_req = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic set_ack_mode(input int mode);
    @(negedge clk);
    ack_mode = mode;
    @(posedge clk);
    #1;
  endtask

  task automatic finish_test(input int num, input string name, input int errs_before);
    int waited;
    i_executed_req = 1'b0;
    waited         = 0;
    while (exp_q.size() != 0 && !timed_out) begin
      if (waited == WAIT_LIMIT) begin
        timeout_fail("draining of outstanding results");
      end else begin
        waited++;
        @(posedge clk);
        #1;
      end
    end
    check_value("result count", 64'(n_results), 64'(n_accepts));
    $display("test %0d %s: done with %0d errors, %0d results so far",
             num, name, n_errors - errs_before, n_results);
  endtask

  initial begin
    int errs;
    rst            = 1'b1;
    i_executed_req = 1'b0;
    i_pc           = '0;
    i_inst         = '0;
    i_addr         = '0;
    i_ren          = 1'b0;
    i_wen          = 1'b0;
    i_funct3       = '0;
    i_wdata        = '0;
    i_rd           = '0;
    i_rd_wen       = 1'b0;
    i_rd_wdata     = '0;
    i_memoryed_ack = 1'b1;
    stim_rng       = 32'h825c;
    ack_rng        = ~32'h825c;  // Separate stream for the write-back stalls
    pc_next        = 64'h1000;
    ack_mode       = 0;
    n_checks       = 0;
    n_errors       = 0;
    n_accepts      = 0;
    n_results      = 0;
    stalls         = 0;
    prev_accept    = 1'b0;
    hold_valid     = 1'b0;
    timed_out      = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    errs = n_errors;
    @(negedge clk);
    check_value("o_memoryed_req", 64'(o_memoryed_req), 64'd0);
    check_value("o_executed_ack", 64'(o_executed_ack), 64'd1);
    compare_result(current_outputs(), '0);
    @(posedge clk);
    #1;
    finish_test(1, "reset state", errs);

    // Every word gets written once so no load sees unknown data
    errs = n_errors;
    for (int w = 0; w < RAM_WORDS; w++) begin
      send_instr(KIND_STORE, F3_LD, 64'(w * 8), {rand_stim(), rand_stim()});
    end
    for (int i = 0; i < 400; i++) begin
      send_random(int'(rand_stim() % 2));
    end
    finish_test(2, "store and load widths", errs);

    errs = n_errors;
    for (int i = 0; i < 200; i++) begin
      send_random(int'(rand_stim() % 3));
    end
    finish_test(3, "pass-through fields", errs);

    errs = n_errors;
    set_ack_mode(1);
    for (int i = 0; i < 200; i++) begin
      send_random(int'(rand_stim() % 3));
    end
    finish_test(4, "back-pressure", errs);

    errs = n_errors;
    set_ack_mode(0);
    stalls = 0;
    for (int i = 0; i < 100; i++) begin
      send_random(int'(rand_stim() % 3));
    end
    check_value("stalled cycles at full rate", 64'(stalls), 64'd0);
    finish_test(5, "full throughput", errs);

    errs = n_errors;
    for (int i = 0; i < 100; i++) begin
      idle_cycles(int'(rand_stim() % 4));
      send_random(int'(rand_stim() % 3));
    end
    idle_cycles(4);
    finish_test(6, "idle gating", errs);

    report_and_finish();
  end

endmodule

// File: design/mem_top.sv
// Top level of the memory stage and its data RAM

module mem_top #(
  parameter int RAM_WORDS = 512
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_executed_req,
  output logic                 o_executed_ack,
  input  rv_mem_pkg::xlen_t    i_pc,
  input  rv_mem_pkg::inst_t    i_inst,
  input  rv_mem_pkg::xlen_t    i_addr,
  input  logic                 i_ren,
  input  logic                 i_wen,
  input  rv_mem_pkg::funct3_t  i_funct3,
  input  rv_mem_pkg::xlen_t    i_wdata,
  input  rv_mem_pkg::reg_idx_t i_rd,
  input  logic                 i_rd_wen,
  input  rv_mem_pkg::xlen_t    i_rd_wdata,
  output logic                 o_memoryed_req,
  input  logic                 i_memoryed_ack,
  output rv_mem_pkg::xlen_t    o_pc,
  output rv_mem_pkg::inst_t    o_inst,
  output rv_mem_pkg::reg_idx_t o_rd,
  output logic                 o_rd_wen,
  output rv_mem_pkg::xlen_t    o_rd_wdata,
  output rv_mem_pkg::xlen_t    o_rdata
);

  import rv_mem_pkg::*;

  logic                         ram_ce;
  logic                         ram_we;
  logic [$clog2(RAM_WORDS)-1:0] ram_addr;   // Word index into the RAM
  byte_en_t                     ram_be;
  xlen_t                        ram_wdata;
  xlen_t                        ram_rdata;

  mem_stage #(
    .RAM_WORDS (RAM_WORDS)
  ) u_mem_stage (
    .clk            (clk),
    .rst            (rst),
    .i_executed_req (i_executed_req),
    .o_executed_ack (o_executed_ack),
    .i_pc           (i_pc),
    .i_inst         (i_inst),
    .i_addr         (i_addr),
    .i_ren          (i_ren),
    .i_wen          (i_wen),
    .i_funct3       (i_funct3),
    .i_wdata        (i_wdata),
    .i_rd           (i_rd),
    .i_rd_wen       (i_rd_wen),
    .i_rd_wdata     (i_rd_wdata),
    .o_memoryed_req (o_memoryed_req),
    .i_memoryed_ack (i_memoryed_ack),
    .o_pc           (o_pc),
    .o_inst         (o_inst),
    .o_rd           (o_rd),
    .o_rd_wen       (o_rd_wen),
    .o_rd_wdata     (o_rd_wdata),
    .o_rdata        (o_rdata),
    .o_ram_ce       (ram_ce),
    .o_ram_we       (ram_we),
    .o_ram_addr     (ram_addr),
    .o_ram_be       (ram_be),
    .o_ram_wdata    (ram_wdata),
    .i_ram_rdata    (ram_rdata)
  );

  data_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_data_ram (
    .clk     (clk),
    .i_ce    (ram_ce),
    .i_we    (ram_we),
    .i_addr  (ram_addr),
    .i_be    (ram_be),
    .i_wdata (ram_wdata),
    .o_rdata (ram_rdata)
  );

endmodule

// File: design/mem_stage.sv
// Memory pipeline stage with req/ack handshakes on both sides
// Holds the pass-through fields and drives the access unit

module mem_stage #(
  parameter int RAM_WORDS = 512
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         i_executed_req,
  output logic                         o_executed_ack,
  input  rv_mem_pkg::xlen_t            i_pc,
  input  rv_mem_pkg::inst_t            i_inst,
  input  rv_mem_pkg::xlen_t            i_addr,
  input  logic                         i_ren,
  input  logic                         i_wen,
  input  rv_mem_pkg::funct3_t          i_funct3,
  input  rv_mem_pkg::xlen_t            i_wdata,
  input  rv_mem_pkg::reg_idx_t         i_rd,
  input  logic                         i_rd_wen,
  input  rv_mem_pkg::xlen_t            i_rd_wdata,
  output logic                         o_memoryed_req,
  input  logic                         i_memoryed_ack,
  output rv_mem_pkg::xlen_t            o_pc,
  output rv_mem_pkg::inst_t            o_inst,
  output rv_mem_pkg::reg_idx_t         o_rd,
  output logic                         o_rd_wen,
  output rv_mem_pkg::xlen_t            o_rd_wdata,
  output rv_mem_pkg::xlen_t            o_rdata,
  output logic                         o_ram_ce,
  output logic                         o_ram_we,
  output logic [$clog2(RAM_WORDS)-1:0] o_ram_addr,
  output rv_mem_pkg::byte_en_t         o_ram_be,
  output rv_mem_pkg::xlen_t            o_ram_wdata,
  input  rv_mem_pkg::xlen_t            i_ram_rdata
);

  import rv_mem_pkg::*;

  logic     req_q;
  logic     accept;
  xlen_t    pc_q;
  inst_t    inst_q;
  reg_idx_t rd_q;
  logic     rd_wen_q;
  xlen_t    rd_wdata_q;
  xlen_t    unit_rdata;

  // Ready unless a result is waiting for the write-back side
  assign o_executed_ack = !req_q || i_memoryed_ack;
  assign accept         = i_executed_req && o_executed_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_q <= 1'b0;
    end else if (accept) begin
      req_q <= 1'b1;
    end else if (i_memoryed_ack) begin
      req_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pc_q       <= i_pc;
      inst_q     <= i_inst;
      rd_q       <= i_rd;
      rd_wen_q   <= i_rd_wen;
      rd_wdata_q <= i_rd_wdata;
    end
  end

  mem_access_unit #(
    .RAM_WORDS (RAM_WORDS)
  ) u_access (
    .clk         (clk),
    .rst         (rst),
    .i_ena       (accept),
    .i_addr      (i_addr),
    .i_ren       (i_ren),
    .i_wen       (i_wen),
    .i_funct3    (i_funct3),
    .i_wdata     (i_wdata),
    .o_ram_ce    (o_ram_ce),
    .o_ram_we    (o_ram_we),
    .o_ram_addr  (o_ram_addr),
    .o_ram_be    (o_ram_be),
    .o_ram_wdata (o_ram_wdata),
    .i_ram_rdata (i_ram_rdata),
    .o_rdata     (unit_rdata)
  );

  // Output fields read zero while nothing is offered
  assign o_memoryed_req = req_q;
  assign o_pc           = req_q ? pc_q : '0;
  assign o_inst         = req_q ? inst_q : '0;
  assign o_rd           = req_q ? rd_q : '0;
  assign o_rd_wen       = req_q ? rd_wen_q : 1'b0;
  assign o_rd_wdata     = req_q ? rd_wdata_q : '0;
  assign o_rdata        = req_q ? unit_rdata : '0;

endmodule

// File: design/mem_access_unit.sv
// Load/store access unit: store lane enables and data alignment
// Load lane extraction with sign or zero extension

module mem_access_unit #(
  parameter int RAM_WORDS = 512
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         i_ena,
  input  rv_mem_pkg::xlen_t            i_addr,
  input  logic                         i_ren,
  input  logic                         i_wen,
  input  rv_mem_pkg::funct3_t          i_funct3,
  input  rv_mem_pkg::xlen_t            i_wdata,
  output logic                         o_ram_ce,
  output logic                         o_ram_we,
  output logic [$clog2(RAM_WORDS)-1:0] o_ram_addr,
  output rv_mem_pkg::byte_en_t         o_ram_be,
  output rv_mem_pkg::xlen_t            o_ram_wdata,
  input  rv_mem_pkg::xlen_t            i_ram_rdata,
  output rv_mem_pkg::xlen_t            o_rdata
);

  import rv_mem_pkg::*;

  localparam int AW = $clog2(RAM_WORDS);

  logic [2:0] acc_off;    // Byte offset aligned to the access size
  byte_en_t   size_mask;

  // Registered load attributes, used one cycle after the RAM read
  logic       ld_pend;
  funct3_t    ld_funct3;
  logic [2:0] ld_off;

  xlen_t      ld_word;
  xlen_t      ld_ext;

  // Low address bits below the access size are dropped
  always_comb begin
    case (i_funct3[1:0])
      2'd0: begin
        acc_off   = i_addr[2:0];
        size_mask = 8'h01;
      end
      2'd1: begin
        acc_off   = {i_addr[2:1], 1'b0};
        size_mask = 8'h03;
      end
      2'd2: begin
        acc_off   = {i_addr[2], 2'b00};
        size_mask = 8'h0f;
      end
      default: begin
        acc_off   = 3'd0;
        size_mask = 8'hff;
      end
    endcase
  end

  // RAM strobes pulse only on the accept cycle
  assign o_ram_ce    = i_ena && (i_ren || i_wen);
  assign o_ram_we    = i_ena && i_wen;
  assign o_ram_addr  = i_addr[AW+2:3];
  assign o_ram_be    = size_mask << acc_off;
  assign o_ram_wdata = i_wdata << {acc_off, 3'b000};

  always_ff @(posedge clk) begin
    if (rst) begin
      ld_pend <= 1'b0;
    end else if (i_ena) begin
      ld_pend <= i_ren && !i_wen;
    end
  end

  always_ff @(posedge clk) begin
    if (i_ena) begin
      ld_funct3 <= i_funct3;
      ld_off    <= acc_off;
    end
  end

  assign ld_word = i_ram_rdata >> {ld_off, 3'b000};  // Addressed bytes moved to lane 0

  always_comb begin
    case (ld_funct3)
      F3_LB:   ld_ext = {{56{ld_word[7]}}, ld_word[7:0]};
      F3_LH:   ld_ext = {{48{ld_word[15]}}, ld_word[15:0]};
      F3_LW:   ld_ext = {{32{ld_word[31]}}, ld_word[31:0]};
      F3_LD:   ld_ext = ld_word;
      F3_LBU:  ld_ext = {56'd0, ld_word[7:0]};
      F3_LHU:  ld_ext = {48'd0, ld_word[15:0]};
      F3_LWU:  ld_ext = {32'd0, ld_word[31:0]};
      default: ld_ext = '0;  // Code 111 has no RV64 load
    endcase
  end

  assign o_rdata = ld_pend ? ld_ext : '0;

endmodule

// File: design/data_ram.sv
// Byte-enabled data RAM, 64 bits wide
// Synchronous write and registered synchronous read

module data_ram #(
  parameter int RAM_WORDS = 512
) (
  input  logic                         clk,
  input  logic                         i_ce,
  input  logic                         i_we,
  input  logic [$clog2(RAM_WORDS)-1:0] i_addr,
  input  rv_mem_pkg::byte_en_t         i_be,
  input  rv_mem_pkg::xlen_t            i_wdata,
  output rv_mem_pkg::xlen_t            o_rdata
);

  import rv_mem_pkg::*;

  xlen_t mem [RAM_WORDS];

  // Write only the enabled lanes of the addressed word
  always_ff @(posedge clk) begin
    if (i_ce && i_we) begin
      for (int b = 0; b < 8; b++) begin
        if (i_be[b]) begin
          mem[i_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // Read register holds its value between reads
  always_ff @(posedge clk) begin
    if (i_ce && !i_we) begin
      o_rdata <= mem[i_addr];
    end
  end

endmodule

// File: design/rv_mem_pkg.sv
// Shared types of the memory stage and data RAM
// RV64 funct3 codes for loads; stores use the same low two bits for size

package rv_mem_pkg;

  // 64-bit data word for pc, addresses and data
  typedef logic [63:0] xlen_t;

  // 32-bit instruction word
  typedef logic [31:0] inst_t;

  // Register file index
  typedef logic [4:0] reg_idx_t;

  // Access size in bits 1:0, zero-extend flag in bit 2
  typedef logic [2:0] funct3_t;

  // One enable per byte lane of a data word
  typedef logic [7:0] byte_en_t;

  localparam funct3_t F3_LB  = 3'b000;
  localparam funct3_t F3_LH  = 3'b001;
  localparam funct3_t F3_LW  = 3'b010;
  localparam funct3_t F3_LD  = 3'b011;
  localparam funct3_t F3_LBU = 3'b100;
  localparam funct3_t F3_LHU = 3'b101;
  localparam funct3_t F3_LWU = 3'b110;

endpackage
